/* src/fifo_params.svh */
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// width of one word on the write port
`define FIFO_W_DATA_W 32

// width of one word on the read port
`define FIFO_R_DATA_W 8

// address width counted in narrow (read) words
// 6 bits gives 64 bytes of storage
`define FIFO_ADDR_W 6

`endif

/* src/fifo_pkg.sv */
`default_nettype none

`include "fifo_params.svh"

package fifo_pkg;

   // write to read width ratio expressed as a shift
   localparam int RATIO_LOG = $clog2(`FIFO_W_DATA_W / `FIFO_R_DATA_W);

   // address widths of each side, wrap bit not included
   localparam int W_PTR_W = `FIFO_ADDR_W - RATIO_LOG;
   localparam int R_PTR_W = `FIFO_ADDR_W;

   typedef logic [`FIFO_W_DATA_W-1:0] w_word_t;
   typedef logic [`FIFO_R_DATA_W-1:0] r_word_t;
   typedef logic [`FIFO_ADDR_W-1:0]   level_t;

endpackage

`default_nettype wire

/* src/gray_ptr_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_counter #(
   parameter int WIDTH = 4
) (
   input  wire              clk_i,
   input  wire              reset_i,
   input  wire              en_i,
   output logic [WIDTH-1:0] bin_o,
   output logic [WIDTH-1:0] gray_o
);

   logic [WIDTH-1:0] bin_next;

   // next binary count, wraps at 2**WIDTH by itself
   assign bin_next = bin_o + WIDTH'(1);

   // both forms are registered together so they always describe the same count
   // the gray copy leaves the domain, only one of its bits moves per step
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         bin_o  <= '0;
         gray_o <= '0;
      end else if (en_i) begin
         bin_o  <= bin_next;
         gray_o <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

`default_nettype wire

/* src/gray_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module gray_sync #(
   parameter int WIDTH = 4
) (
   input  wire              clk_i,
   input  wire              reset_i,
   input  wire [WIDTH-1:0]  gray_i,
   output logic [WIDTH-1:0] bin_o
);

   logic [WIDTH-1:0] meta_q;
   logic [WIDTH-1:0] sync_q;

   // first stage may go metastable, second stage is the one used locally
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= gray_i;
         sync_q <= meta_q;
      end
   end

   // gray to binary, each bit is the xor of itself and all bits above it
   always_comb begin
      for (int i = 0; i < WIDTH; i++) begin
         bin_o[i] = ^(sync_q >> i);
      end
   end

endmodule

`default_nettype wire

/* src/fifo_level_calc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fifo_params.svh"

module fifo_level_calc import fifo_pkg::*; #(
   parameter int PTR_W      = R_PTR_W + 1,
   parameter int SELF_SHIFT = 0,
   parameter int PEER_SHIFT = RATIO_LOG
) (
   input  wire [PTR_W-1:0]                       self_ptr_i,
   input  wire [PTR_W+SELF_SHIFT-PEER_SHIFT-1:0] peer_ptr_i,
   output level_t                                level_o,
   output logic                                  empty_o,
   output logic                                  full_o
);

   localparam int CALC_W = `FIFO_ADDR_W + 2;
   localparam logic [CALC_W-1:0] FIFO_SIZE  = CALC_W'(1) << `FIFO_ADDR_W;
   localparam logic [CALC_W-1:0] WRAP_MASK  = (FIFO_SIZE << 1) - CALC_W'(1);
   // one word of this side, counted in narrow words
   localparam logic [CALC_W-1:0] LOCAL_WORD = CALC_W'(1) << SELF_SHIFT;
   localparam logic [CALC_W-1:0] FULL_LIMIT = FIFO_SIZE - LOCAL_WORD;

   logic [CALC_W-1:0] self_n;
   logic [CALC_W-1:0] peer_n;
   logic [CALC_W-1:0] diff;
   logic [CALC_W-1:0] level_int;

   // both pointers scaled to narrow word units
   assign self_n = CALC_W'(self_ptr_i) << SELF_SHIFT;
   assign peer_n = CALC_W'(peer_ptr_i) << PEER_SHIFT;

   // normalized pointers wrap at FIFO_ADDR_W+1 bits
   assign diff = (self_n - peer_n) & WRAP_MASK;

   // seen from the write side the difference is +level, from the read side -level;
   // level never exceeds the FIFO size so folding the upper half recovers it either way
   assign level_int = (diff > FIFO_SIZE) ? ((FIFO_SIZE << 1) - diff) : diff;

   assign empty_o = (level_int < LOCAL_WORD);
   assign full_o  = (level_int > FULL_LIMIT);

   // at exactly full this wraps to 0, full_o tells it apart from empty
   assign level_o = level_int[`FIFO_ADDR_W-1:0];

endmodule

`default_nettype wire

/* src/asym_dual_port_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module asym_dual_port_ram import fifo_pkg::*; (
   // wide write port
   input  wire               w_clk_i,
   input  wire               w_en_i,
   input  wire [W_PTR_W-1:0] w_addr_i,
   input  wire w_word_t      w_data_i,

   // narrow read port
   input  wire               r_clk_i,
   input  wire               r_en_i,
   input  wire [R_PTR_W-1:0] r_addr_i,
   output r_word_t           r_data_o
);

   localparam int RATIO  = 1 << RATIO_LOG;
   localparam int DEPTH  = 1 << R_PTR_W;
   localparam int NARROW = $bits(r_word_t);

   // storage kept in narrow words
   r_word_t mem [DEPTH];

   // one wide write fills RATIO consecutive narrow words,
   // least significant byte at the lowest address
   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         for (int i = 0; i < RATIO; i++) begin
            mem[int'(w_addr_i) * RATIO + i] <= w_data_i[i*NARROW +: NARROW];
         end
      end
   end

   // registered read, output holds between accepted reads
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

/* src/async_fifo_asym.sv */
`timescale 1ns/1ps
`default_nettype none

module async_fifo_asym import fifo_pkg::*; (
   // read port
   input  wire          r_clk_i,
   input  wire          r_clk_en_i,
   input  wire          r_en_i,
   output r_word_t      r_data_o,
   output logic         r_empty_o,
   output logic         r_full_o,
   output level_t       r_level_o,

   // write port
   input  wire          w_clk_i,
   input  wire          w_clk_en_i,
   input  wire          w_en_i,
   input  wire w_word_t w_data_i,
   output logic         w_empty_o,
   output logic         w_full_o,
   output level_t       w_level_o,

   // sampled separately by each domain
   input  wire          reset_i
);

   logic w_clk_en_q;
   logic r_clk_en_q;
   logic w_gate_en;
   logic r_gate_en;
   logic w_clk_g;
   logic r_clk_g;
   logic w_en_int;
   logic r_en_int;

   // own pointers and the synchronized copies of the peer pointer
   logic [W_PTR_W:0] w_ptr_bin;
   logic [W_PTR_W:0] w_ptr_gray;
   logic [W_PTR_W:0] r_wptr_bin;
   logic [R_PTR_W:0] r_ptr_bin;
   logic [R_PTR_W:0] r_ptr_gray;
   logic [R_PTR_W:0] w_rptr_bin;

   // clock enables, registered once in their own domain
   always_ff @(posedge w_clk_i) begin
      if (reset_i) begin
         w_clk_en_q <= 1'b0;
      end else begin
         w_clk_en_q <= w_clk_en_i;
      end
   end

   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         r_clk_en_q <= 1'b0;
      end else begin
         r_clk_en_q <= r_clk_en_i;
      end
   end

   // gate latches only follow while the clock is low, so no runt edges;
   // reset keeps the clock alive so the gated logic can clear
   always_latch begin
      if (!w_clk_i) begin
         w_gate_en <= w_clk_en_q | reset_i;
      end
   end

   always_latch begin
      if (!r_clk_i) begin
         r_gate_en <= r_clk_en_q | reset_i;
      end
   end

   assign w_clk_g = w_clk_i & w_gate_en;
   assign r_clk_g = r_clk_i & r_gate_en;

   // no pointer move or memory access past the flags
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   gray_ptr_counter #(.WIDTH(W_PTR_W + 1)) w_ptr_cnt (
      .clk_i   (w_clk_g),
      .reset_i (reset_i),
      .en_i    (w_en_int),
      .bin_o   (w_ptr_bin),
      .gray_o  (w_ptr_gray)
   );

   gray_ptr_counter #(.WIDTH(R_PTR_W + 1)) r_ptr_cnt (
      .clk_i   (r_clk_g),
      .reset_i (reset_i),
      .en_i    (r_en_int),
      .bin_o   (r_ptr_bin),
      .gray_o  (r_ptr_gray)
   );

   // write pointer into the read domain
   gray_sync #(.WIDTH(W_PTR_W + 1)) w_ptr_sync (
      .clk_i   (r_clk_g),
      .reset_i (reset_i),
      .gray_i  (w_ptr_gray),
      .bin_o   (r_wptr_bin)
   );

   // read pointer into the write domain
   gray_sync #(.WIDTH(R_PTR_W + 1)) r_ptr_sync (
      .clk_i   (w_clk_g),
      .reset_i (reset_i),
      .gray_i  (r_ptr_gray),
      .bin_o   (w_rptr_bin)
   );

   fifo_level_calc #(
      .PTR_W      (W_PTR_W + 1),
      .SELF_SHIFT (RATIO_LOG),
      .PEER_SHIFT (0)
   ) w_level_calc (
      .self_ptr_i (w_ptr_bin),
      .peer_ptr_i (w_rptr_bin),
      .level_o    (w_level_o),
      .empty_o    (w_empty_o),
      .full_o     (w_full_o)
   );

   fifo_level_calc #(
      .PTR_W      (R_PTR_W + 1),
      .SELF_SHIFT (0),
      .PEER_SHIFT (RATIO_LOG)
   ) r_level_calc (
      .self_ptr_i (r_ptr_bin),
      .peer_ptr_i (r_wptr_bin),
      .level_o    (r_level_o),
      .empty_o    (r_empty_o),
      .full_o     (r_full_o)
   );

   // memory addresses drop the wrap bit
   asym_dual_port_ram ram (
      .w_clk_i  (w_clk_g),
      .w_en_i   (w_en_int),
      .w_addr_i (w_ptr_bin[W_PTR_W-1:0]),
      .w_data_i (w_data_i),
      .r_clk_i  (r_clk_g),
      .r_en_i   (r_en_int),
      .r_addr_i (r_ptr_bin[R_PTR_W-1:0]),
      .r_data_o (r_data_o)
   );

endmodule

`default_nettype wire

/* test/async_fifo_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module async_fifo_assert import fifo_pkg::*; (
   input wire             w_clk_i,
   input wire             r_clk_i,
   input wire             reset_i,
   input wire [W_PTR_W:0] w_ptr_i,
   input wire [R_PTR_W:0] r_ptr_i,
   input wire             w_full_i,
   input wire             w_empty_i,
   input wire             r_full_i,
   input wire             r_empty_i
);

   // number of assertion failures seen so far
   int fail_count = 0;

   // a full FIFO holds its write pointer
   w_hold_when_full : assert property (
      @(posedge w_clk_i) disable iff (reset_i)
      w_full_i |=> $stable(w_ptr_i)
   ) else begin
      $error("write pointer advanced while w_full_o was high");
      fail_count++;
   end

   // an empty FIFO holds its read pointer
   r_hold_when_empty : assert property (
      @(posedge r_clk_i) disable iff (reset_i)
      r_empty_i |=> $stable(r_ptr_i)
   ) else begin
      $error("read pointer advanced while r_empty_o was high");
      fail_count++;
   end

   w_flags_exclusive : assert property (
      @(posedge w_clk_i) disable iff (reset_i)
      !(w_empty_i && w_full_i)
   ) else begin
      $error("w_empty_o and w_full_o high together");
      fail_count++;
   end

   r_flags_exclusive : assert property (
      @(posedge r_clk_i) disable iff (reset_i)
      !(r_empty_i && r_full_i)
   ) else begin
      $error("r_empty_o and r_full_o high together");
      fail_count++;
   end

endmodule

bind async_fifo_asym async_fifo_assert fifo_checks (
   .w_clk_i   (w_clk_i),
   .r_clk_i   (r_clk_i),
   .reset_i   (reset_i),
   .w_ptr_i   (w_ptr_bin),
   .r_ptr_i   (r_ptr_bin),
   .w_full_i  (w_full_o),
   .w_empty_i (w_empty_o),
   .r_full_i  (r_full_o),
   .r_empty_i (r_empty_o)
);

`default_nettype wire

/* test/async_fifo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fifo_params.svh"

module async_fifo_tb import fifo_pkg::*; ();

   localparam int HALF_PERIOD  = 10;
   localparam int R_CLK_OFFSET = 7;
   localparam int DRIVE_DLY    = 2;
   localparam int RESET_CYCLES = 8;
   localparam int WAIT_LIMIT   = 200;
   localparam int WATCHDOG_NS  = 200000;
   localparam int WORD_BYTES   = `FIFO_W_DATA_W / `FIFO_R_DATA_W;
   localparam int FIFO_BYTES   = 1 << `FIFO_ADDR_W;
   localparam int FIFO_WORDS   = FIFO_BYTES / WORD_BYTES;
   localparam int RAND_WORDS   = 40;

   logic    w_clk_i;
   logic    r_clk_i;
   logic    reset_i;
   logic    w_clk_en_i;
   logic    w_en_i;
   w_word_t w_data_i;
   logic    w_empty_o;
   logic    w_full_o;
   level_t  w_level_o;
   logic    r_clk_en_i;
   logic    r_en_i;
   r_word_t r_data_o;
   logic    r_empty_o;
   logic    r_full_o;
   level_t  r_level_o;

   // bytes in the order the read port must return them
   r_word_t model_q [$];

   integer seed         = 95;
   int     error_count  = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;

   async_fifo_asym DUT (
      .r_clk_i    (r_clk_i),
      .r_clk_en_i (r_clk_en_i),
      .r_en_i     (r_en_i),
      .r_data_o   (r_data_o),
      .r_empty_o  (r_empty_o),
      .r_full_o   (r_full_o),
      .r_level_o  (r_level_o),
      .w_clk_i    (w_clk_i),
      .w_clk_en_i (w_clk_en_i),
      .w_en_i     (w_en_i),
      .w_data_i   (w_data_i),
      .w_empty_o  (w_empty_o),
      .w_full_o   (w_full_o),
      .w_level_o  (w_level_o),
      .reset_i    (reset_i)
   );

   initial begin
      w_clk_i = 1'b0;
      forever #HALF_PERIOD w_clk_i = ~w_clk_i;
   end

   // read clock runs at the same rate but offset
   initial begin
      r_clk_i = 1'b0;
      #R_CLK_OFFSET;
      forever #HALF_PERIOD r_clk_i = ~r_clk_i;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("Fail at time %0d ns: %s expected 0x%0h, got 0x%0h",
                  $time, name, expected, actual);
         error_count++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("Error at time %0d ns: %s", $time, msg);
      error_count++;
   endtask

   task automatic end_test(input string name, input int start_errs);
      tests_run++;
      if (error_count == start_errs) begin
         $display("test %s: done, no errors", name);
      end else begin
         tests_failed++;
         $display("test %s: done, %0d errors", name, error_count - start_errs);
      end
   endtask

   // least significant byte leaves the FIFO first
   task automatic push_word(input w_word_t data);
      for (int i = 0; i < WORD_BYTES; i++) begin
         model_q.push_back(data[i*`FIFO_R_DATA_W +: `FIFO_R_DATA_W]);
      end
   endtask

   task automatic set_w_clk_en(input logic value);
      @(posedge w_clk_i);
      #DRIVE_DLY;
      w_clk_en_i = value;
      // enable register and gate latch need a couple of edges
      repeat (3) @(posedge w_clk_i);
   endtask

   task automatic set_r_clk_en(input logic value);
      @(posedge r_clk_i);
      #DRIVE_DLY;
      r_clk_en_i = value;
      repeat (3) @(posedge r_clk_i);
   endtask

   task automatic write_word(input w_word_t data, output bit accepted);
      @(posedge w_clk_i);
      #DRIVE_DLY;
      w_en_i   = 1'b1;
      w_data_i = data;
      // w_full_o only moves on a write clock edge
      accepted = !w_full_o;
      @(posedge w_clk_i);
      #DRIVE_DLY;
      w_en_i = 1'b0;
      if (accepted) begin
         push_word(data);
      end
   endtask

   task automatic write_until_accepted(input w_word_t data);
      bit acc;
      int tries;
      acc   = 1'b0;
      tries = 0;
      while (!acc && tries < WAIT_LIMIT) begin
         write_word(data, acc);
         tries++;
      end
      if (!acc) begin
         report_error("timeout: write never accepted, FIFO stayed full");
      end
   endtask

   task automatic read_byte();
      int      n;
      r_word_t expected;
      n = 0;
      @(posedge r_clk_i);
      #DRIVE_DLY;
      while (r_empty_o && n < WAIT_LIMIT) begin
         @(posedge r_clk_i);
         #DRIVE_DLY;
         n++;
      end
      if (r_empty_o) begin
         report_error("timeout: r_empty_o stayed high, no byte to read");
      end else begin
         r_en_i = 1'b1;
         @(posedge r_clk_i);
         #DRIVE_DLY;
         r_en_i = 1'b0;
         if (model_q.size() == 0) begin
            report_error("DUT returned a byte that was never written");
         end else begin
            expected = model_q.pop_front();
            check_value("r_data_o", expected, r_data_o);
         end
      end
   endtask

   task automatic wait_r_level(input int target);
      int n;
      n = 0;
      @(posedge r_clk_i);
      #DRIVE_DLY;
      while (r_level_o != target && n < WAIT_LIMIT) begin
         @(posedge r_clk_i);
         #DRIVE_DLY;
         n++;
      end
      if (r_level_o != target) begin
         report_error($sformatf("timeout: r_level_o never reached %0d", target));
      end
   endtask

   task automatic wait_r_full();
      int n;
      n = 0;
      @(posedge r_clk_i);
      #DRIVE_DLY;
      while (!r_full_o && n < WAIT_LIMIT) begin
         @(posedge r_clk_i);
         #DRIVE_DLY;
         n++;
      end
      if (!r_full_o) begin
         report_error("timeout: r_full_o never went high");
      end
   endtask

   // write side has seen every read
   task automatic wait_w_empty();
      int n;
      n = 0;
      @(posedge w_clk_i);
      #DRIVE_DLY;
      while (!(w_empty_o && w_level_o == 0) && n < WAIT_LIMIT) begin
         @(posedge w_clk_i);
         #DRIVE_DLY;
         n++;
      end
      if (!(w_empty_o && w_level_o == 0)) begin
         report_error("timeout: write side never saw the FIFO empty");
      end
   endtask

   task automatic test_reset_state();
      int start_errs;
      start_errs = error_count;
      @(posedge w_clk_i);
      #DRIVE_DLY;
      check_value("w_empty_o", 1, w_empty_o);
      check_value("w_full_o", 0, w_full_o);
      check_value("w_level_o", 0, w_level_o);
      check_value("r_empty_o", 1, r_empty_o);
      check_value("r_full_o", 0, r_full_o);
      check_value("r_level_o", 0, r_level_o);
      end_test("reset state", start_errs);
   endtask

   task automatic test_byte_order();
      w_word_t words [4];
      bit      acc;
      int      start_errs;
      start_errs = error_count;
      words[0] = 32'h11223344;
      words[1] = 32'hA5B6C7D8;
      words[2] = 32'hDEADBEEF;
      words[3] = 32'h0F1E2D3C;
      for (int i = 0; i < 4; i++) begin
         write_word(words[i], acc);
         check_value("write accepted", 1, acc);
      end
      check_value("w_level_o", 4 * WORD_BYTES, w_level_o);
      wait_r_level(4 * WORD_BYTES);
      for (int i = 0; i < 4 * WORD_BYTES; i++) begin
         read_byte();
      end
      check_value("r_empty_o", 1, r_empty_o);
      wait_w_empty();
      end_test("byte order", start_errs);
   endtask

   task automatic test_fill_to_full();
      int      start_errs;
      int      accepted_words;
      int      tries;
      bit      acc;
      w_word_t data;
      start_errs     = error_count;
      accepted_words = 0;
      tries          = 0;
      while (!w_full_o && tries < 2 * FIFO_WORDS) begin
         data = $random(seed);
         write_word(data, acc);
         if (acc) begin
            accepted_words++;
         end
         tries++;
      end
      check_value("accepted words", FIFO_WORDS, accepted_words);
      check_value("w_full_o", 1, w_full_o);
      // level wraps to 0 at exactly full
      check_value("w_level_o", 0, w_level_o);
      wait_r_full();
      check_value("r_level_o", 0, r_level_o);
      for (int i = 0; i < 3; i++) begin
         data = $random(seed);
         write_word(data, acc);
         check_value("write accepted while full", 0, acc);
      end
      check_value("model bytes", FIFO_BYTES, model_q.size());
      for (int i = 0; i < FIFO_BYTES; i++) begin
         read_byte();
      end
      check_value("r_empty_o", 1, r_empty_o);
      check_value("model bytes left", 0, model_q.size());
      wait_w_empty();
      end_test("fill to full", start_errs);
   endtask

   task automatic test_random_traffic();
      int start_errs;
      start_errs = error_count;
      fork
         begin : writer
            int      gap;
            w_word_t data;
            for (int i = 0; i < RAND_WORDS; i++) begin
               gap = $unsigned($random(seed)) % 4;
               repeat (gap) @(posedge w_clk_i);
               data = $random(seed);
               write_until_accepted(data);
            end
         end
         begin : reader
            int gap;
            for (int i = 0; i < RAND_WORDS * WORD_BYTES; i++) begin
               gap = $unsigned($random(seed)) % 4;
               repeat (gap) @(posedge r_clk_i);
               read_byte();
            end
         end
      join
      check_value("model bytes left", 0, model_q.size());
      check_value("r_empty_o", 1, r_empty_o);
      wait_w_empty();
      end_test("random traffic", start_errs);
   endtask

   task automatic test_clock_gating();
      int      start_errs;
      bit      acc;
      r_word_t held;
      w_word_t data;
      start_errs = error_count;
      for (int i = 0; i < 2; i++) begin
         data = $random(seed);
         write_word(data, acc);
         check_value("write accepted", 1, acc);
      end
      wait_r_level(2 * WORD_BYTES);
      held = model_q[0];
      read_byte();

      // strobes are ignored while the write clock is gated off
      set_w_clk_en(1'b0);
      #DRIVE_DLY;
      w_en_i   = 1'b1;
      w_data_i = $random(seed);
      repeat (6) @(posedge w_clk_i);
      #DRIVE_DLY;
      w_en_i = 1'b0;
      repeat (10) @(posedge r_clk_i);
      #DRIVE_DLY;
      check_value("r_level_o", 2 * WORD_BYTES - 1, r_level_o);

      set_r_clk_en(1'b0);
      #DRIVE_DLY;
      r_en_i = 1'b1;
      repeat (6) @(posedge r_clk_i);
      #DRIVE_DLY;
      r_en_i = 1'b0;
      check_value("r_level_o", 2 * WORD_BYTES - 1, r_level_o);
      check_value("r_data_o", held, r_data_o);

      set_w_clk_en(1'b1);
      set_r_clk_en(1'b1);
      data = $random(seed);
      write_word(data, acc);
      check_value("write accepted", 1, acc);
      wait_r_level(3 * WORD_BYTES - 1);
      for (int i = 0; i < 3 * WORD_BYTES - 1; i++) begin
         read_byte();
      end
      check_value("r_empty_o", 1, r_empty_o);
      check_value("model bytes left", 0, model_q.size());
      wait_w_empty();
      end_test("clock enable gating", start_errs);
   endtask

   initial begin
      reset_i    = 1'b1;
      w_clk_en_i = 1'b0;
      w_en_i     = 1'b0;
      w_data_i   = '0;
      r_clk_en_i = 1'b0;
      r_en_i     = 1'b0;
      // reset must span 8 edges of each clock
      fork
         repeat (RESET_CYCLES) @(posedge w_clk_i);
         repeat (RESET_CYCLES) @(posedge r_clk_i);
      join
      #DRIVE_DLY;
      reset_i = 1'b0;

      test_reset_state();
      set_w_clk_en(1'b1);
      set_r_clk_en(1'b1);
      test_byte_order();
      test_fill_to_full();
      test_random_traffic();
      test_clock_gating();

      error_count += DUT.fifo_checks.fail_count;
      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, error_count);
      if (error_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      #WATCHDOG_NS;
      $display("simulation watchdog expired before the tests finished");
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/fifo_pkg.sv
src/gray_ptr_counter.sv
src/gray_sync.sv
src/fifo_level_calc.sv
src/asym_dual_port_ram.sv
src/async_fifo_asym.sv
test/async_fifo_assert.sv
test/async_fifo_tb.sv

/* Bender.yml */
package:
  name: async_fifo_asym

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/fifo_pkg.sv
      - src/gray_ptr_counter.sv
      - src/gray_sync.sv
      - src/fifo_level_calc.sv
      - src/asym_dual_port_ram.sv
      - src/async_fifo_asym.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/async_fifo_assert.sv
      - test/async_fifo_tb.sv
